//--- logic/weight_pkg.sv
package weight_pkg;

    // ###################################################################
    // grid geometry
    // ###################################################################

    localparam int num_lanes   = 16;
    localparam int num_rows    = 8;
    localparam int weight_bits = 8;

    // data word of a command, wide enough for one step per lane
    localparam int data_bits   = 2 * num_lanes;

    typedef logic [$clog2(num_lanes)-1:0]   lane_idx_t;
    typedef logic [$clog2(num_rows)-1:0]    row_idx_t;
    typedef logic signed [weight_bits-1:0]  weight_t;

    // -1, 0, +1 in normal use; 2'b10 counts as -2
    typedef logic signed [1:0]              step_t;

    // ###################################################################
    // command encoding
    // ###################################################################

    typedef enum logic [1:0] {
        op_load = 2'd0,
        op_inc  = 2'd1,
        op_read = 2'd2
    } weight_op_t;

    // load view: weight sits in the low byte
    typedef struct packed {
        logic [data_bits-weight_bits-1:0] unused;
        weight_t                          value;
    } load_word_t;

    // increment view: lane 0 in the low two bits
    typedef step_t [num_lanes-1:0] step_vec_t;

    typedef union packed {
        load_word_t load_word;
        step_vec_t  step_vec;
    } cmd_data_u;

    typedef struct packed {
        weight_op_t op;
        lane_idx_t  lane;
        row_idx_t   row;
        cmd_data_u  data;
    } weight_cmd_t;

    // lane and row come back with the value so the host can match reads
    typedef struct packed {
        lane_idx_t lane;
        row_idx_t  row;
        weight_t   value;
    } weight_resp_t;

endpackage

//--- logic/cmd_queue.sv
`timescale 1ns/10ps

module cmd_queue #(
    parameter int queue_depth = 4
) (
    input  logic                     clk,
    input  logic                     rst,

    input  weight_pkg::weight_cmd_t  in_cmd,
    input  logic                     in_valid,
    output logic                     in_ready,

    output weight_pkg::weight_cmd_t  out_cmd,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import weight_pkg::*;

    localparam int ptr_bits = $clog2(queue_depth);
    localparam int cnt_bits = ptr_bits + 1;

    // ###################################################################
    // storage and pointers
    // ###################################################################

    weight_cmd_t         mem [queue_depth];

    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;

    logic                full;
    logic                push;
    logic                pop;

    assign full      = (count == cnt_bits'(queue_depth));
    assign out_valid = (count != '0);

    // full queue still takes a command when one leaves on the same edge
    assign in_ready  = !full || out_ready;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // head of queue straight from storage
    assign out_cmd   = mem[rd_ptr];

    // ###################################################################
    // write side
    // ###################################################################

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (push) begin
            // depth is a power of two, so the pointer wraps by itself
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // ###################################################################
    // read side and occupancy
    // ###################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/weight_exec.sv
`timescale 1ns/10ps

module weight_exec (
    input  logic                      clk,
    input  logic                      rst,

    input  weight_pkg::weight_cmd_t   cmd,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,

    output weight_pkg::weight_resp_t  resp,
    output logic                      resp_valid,
    input  logic                      resp_ready
);

    import weight_pkg::*;

    // clamp limits of the signed weight range
    localparam weight_t w_max = {1'b0, {(weight_bits-1){1'b1}}};
    localparam weight_t w_min = {1'b1, {(weight_bits-1){1'b0}}};

    // ###################################################################
    // saturating add of one step to one weight
    // ###################################################################

    function automatic weight_t sat_add(weight_t w, step_t s);
        logic signed [weight_bits:0] sum;
        sum = w + s;
        if (sum > w_max) begin
            return w_max;
        end else if (sum < w_min) begin
            return w_min;
        end
        return sum[weight_bits-1:0];
    endfunction

    // ###################################################################
    // handshake
    // ###################################################################

    logic cmd_fire;
    logic is_load;
    logic is_inc;
    logic is_read;

    // a held response stalls everything behind it
    assign cmd_ready = !resp_valid || resp_ready;
    assign cmd_fire  = cmd_valid && cmd_ready;

    always_comb begin
        is_load = 1'b0;
        is_inc  = 1'b0;
        is_read = 1'b0;
        case (cmd.op)
            op_load: is_load = 1'b1;
            op_inc:  is_inc  = 1'b1;
            op_read: is_read = 1'b1;
            default: ;
        endcase
    end

    // ###################################################################
    // weight grid
    // ###################################################################

    weight_t grid    [num_lanes][num_rows];

    // addressed row, all lanes, before and after the step
    weight_t row_now [num_lanes];
    weight_t row_inc [num_lanes];
    weight_t read_value;

    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            row_now[l] = grid[l][cmd.row];
            row_inc[l] = sat_add(row_now[l], cmd.data.step_vec[l]);
        end
    end

    assign read_value = grid[cmd.lane][cmd.row];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < num_lanes; l++) begin
                for (int r = 0; r < num_rows; r++) begin
                    grid[l][r] <= '0;
                end
            end
        end else if (cmd_fire) begin
            if (is_load) begin
                grid[cmd.lane][cmd.row] <= cmd.data.load_word.value;
            end
            // lane field is don't-care here, every lane steps
            if (is_inc) begin
                for (int l = 0; l < num_lanes; l++) begin
                    grid[l][cmd.row] <= row_inc[l];
                end
            end
        end
    end

    // ###################################################################
    // read response
    // ###################################################################

    always_ff @(posedge clk) begin
        if (cmd_fire && is_read) begin
            resp.lane  <= cmd.lane;
            resp.row   <= cmd.row;
            resp.value <= read_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (cmd_fire && is_read) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            // host took it, nothing new behind it
            resp_valid <= 1'b0;
        end
    end

endmodule

//--- logic/weight_manager.sv
`timescale 1ns/10ps

module weight_manager #(
    parameter int queue_depth = 4
) (
    input  logic                      clk,
    input  logic                      rst,

    // host command port
    input  weight_pkg::weight_cmd_t   cmd,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,

    // host response port
    output weight_pkg::weight_resp_t  resp,
    output logic                      resp_valid,
    input  logic                      resp_ready
);

    import weight_pkg::*;

    // ###################################################################
    // queue to executor link
    // ###################################################################

    weight_cmd_t q_cmd;
    logic        q_valid;
    logic        q_ready;

    cmd_queue #(
        .queue_depth (queue_depth)
    ) u_cmd_queue (
        .clk       (clk),
        .rst       (rst),
        .in_cmd    (cmd),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .out_cmd   (q_cmd),
        .out_valid (q_valid),
        .out_ready (q_ready)
    );

    // executes in order; a stalled response backs up into the queue
    weight_exec u_weight_exec (
        .clk        (clk),
        .rst        (rst),
        .cmd        (q_cmd),
        .cmd_valid  (q_valid),
        .cmd_ready  (q_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

endmodule

//--- verification/weight_manager_props.sv
`timescale 1ns/10ps

module weight_manager_props (
    input logic                     clk,
    input logic                     rst,
    input weight_pkg::weight_cmd_t  cmd,
    input logic                     cmd_valid,
    input logic                     cmd_ready,
    input weight_pkg::weight_resp_t resp,
    input logic                     resp_valid,
    input logic                     resp_ready
);

    // ####################################################################
    // handshake stability
    // ####################################################################

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response dropped or changed while the host stalled it");

    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("command dropped or changed while the DUT stalled it");

    // ####################################################################
    // state after reset
    // ####################################################################

    ready_after_reset: assert property (@(posedge clk) rst |=> cmd_ready)
        else $error("cmd_ready low on the cycle after reset");

    idle_after_reset: assert property (@(posedge clk) rst |=> !resp_valid)
        else $error("resp_valid high on the cycle after reset");

endmodule

bind weight_manager weight_manager_props props (
    .clk        (clk),
    .rst        (rst),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
);

//--- verification/weight_manager_tb.sv
`timescale 1ns/10ps

module weight_manager_tb;

    import weight_pkg::*;

    localparam int    depth        = 4;
    localparam string pattern_file = "verification/weight_patterns.txt";

    logic         clk;
    logic         rst;
    weight_cmd_t  cmd;
    logic         cmd_valid;
    logic         cmd_ready;
    weight_resp_t resp;
    logic         resp_valid;
    logic         resp_ready;

    // one entry per command line of the pattern file
    logic [1:0]   pat_op  [$];
    weight_cmd_t  pat_cmd [$];
    weight_t      pat_exp [$];

    // responses still owed by the DUT in the order they are due
    weight_resp_t expected [$];
    weight_resp_t exp_head;

    int           cycles;
    int           cycle_limit;
    logic         hold_resp;
    logic         stall_seen;

    weight_manager #(
        .queue_depth (depth)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    always #5 clk = ~clk;

    // ####################################################################
    // checks
    // ####################################################################

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_weight(input string name, input weight_t got, input weight_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_resp(input weight_resp_t got, input weight_resp_t exp);
        if (got.lane !== exp.lane) begin
            stop_on_error($sformatf("[FAIL] resp.lane got %h expected %h",
                                    got.lane, exp.lane));
        end
        if (got.row !== exp.row) begin
            stop_on_error($sformatf("[FAIL] resp.row got %h expected %h",
                                    got.row, exp.row));
        end
        check_weight("resp.value", got.value, exp.value);
    endtask

    // ####################################################################
    // pattern file and command driving
    // ####################################################################

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_lane;
        logic [31:0] f_row;
        logic [31:0] f_data;
        logic [31:0] f_exp;
        weight_cmd_t c;
        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            stop_on_error("could not open the pattern file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h", f_op, f_lane, f_row, f_data, f_exp);
            if (n == 5) begin
                c.op   = weight_op_t'(f_op[1:0]);
                c.lane = lane_idx_t'(f_lane);
                c.row  = row_idx_t'(f_row);
                c.data = f_data;
                pat_op.push_back(f_op[1:0]);
                pat_cmd.push_back(c);
                pat_exp.push_back(weight_t'(f_exp));
            end else if (n > 0) begin
                stop_on_error($sformatf("pattern line could not be parsed: %s", line));
            end
        end
        $fclose(fd);
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic send_cmd(input weight_cmd_t c);
        int   stall;
        logic accepted;
        stall     = 0;
        cmd       = c;
        cmd_valid = 1'b1;
        forever begin
            @(posedge clk);
            accepted = cmd_ready;
            #1;
            if (accepted) begin
                break;
            end
            stall++;
            if (hold_resp) begin
                stall_seen = 1'b1;
                // let the held responses drain once the queue has backed up
                if (stall >= 4) begin
                    hold_resp = 1'b0;
                end
            end
        end
        cmd_valid = 1'b0;
    endtask

    // op 3 lines steer the testbench and never reach the DUT
    task automatic run_control(input weight_cmd_t c);
        if (c.data.load_word.value[0]) begin
            hold_resp  = 1'b1;
            stall_seen = 1'b0;
        end else begin
            hold_resp = 1'b0;
            if (!stall_seen) begin
                stop_on_error("cmd_ready never went low while responses were held");
            end
        end
    endtask

    // ####################################################################
    // response side
    // ####################################################################

    initial begin : backpressure
        logic held;
        void'($urandom(79444));
        forever begin
            @(posedge clk);
            held = hold_resp;
            #1;
            resp_ready = held ? 1'b0 : (($urandom % 100) < 60);
        end
    end

    always @(posedge clk) begin
        if (!rst && resp_valid && resp_ready) begin
            if (expected.size() == 0) begin
                stop_on_error("a response arrived with no read outstanding");
            end else begin
                exp_head = expected.pop_front();
                check_resp(resp, exp_head);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    // ####################################################################
    // main sequence
    // ####################################################################

    initial begin : main
        weight_resp_t e;
        clk         = 1'b0;
        rst         = 1'b1;
        cmd         = '0;
        cmd_valid   = 1'b0;
        resp_ready  = 1'b0;
        hold_resp   = 1'b0;
        stall_seen  = 1'b0;
        cycles      = 0;
        cycle_limit = 100;
        load_patterns();
        cycle_limit = 20 * pat_op.size() + 100;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (pat_op[i]) begin
            if (pat_op[i] == 2'd3) begin
                run_control(pat_cmd[i]);
            end else begin
                if (pat_op[i] == op_read) begin
                    e.lane  = pat_cmd[i].lane;
                    e.row   = pat_cmd[i].row;
                    e.value = pat_exp[i];
                    expected.push_back(e);
                end
                send_cmd(pat_cmd[i]);
            end
        end

        while (expected.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- verification/weight_patterns.txt
# columns in hex: op lane row data expect; op 0 load, 1 increment, 2 read, 3 testbench control
# expect is the read value; op 3 data 1 holds resp_ready low, data 0 checks cmd_ready fell
# reads right after reset
2 0 0 00000000 00
2 f 7 00000000 00
2 5 3 00000000 00
2 a 6 00000000 00
# load then read back, neighbours stay zero
0 3 2 0000005a 00
2 3 2 00000000 5a
2 4 2 00000000 00
2 3 1 00000000 00
0 7 5 abcdef9c 00
2 7 5 00000000 9c
# mixed steps on row 2 (+1 -1 0 +1 per group of four lanes), lane field ignored
1 9 2 4d4d4d4d 00
2 0 2 00000000 01
2 1 2 00000000 ff
2 2 2 00000000 00
2 3 2 00000000 5b
2 d 2 00000000 ff
2 f 2 00000000 01
2 7 5 00000000 9c
2 0 3 00000000 00
# saturation at both ends of the range
0 1 0 0000007e 00
1 0 0 55555555 00
1 0 0 55555555 00
1 0 0 55555555 00
0 2 4 00000081 00
1 0 4 ffffffff 00
1 0 4 ffffffff 00
1 0 4 ffffffff 00
2 1 0 00000000 7f
2 0 0 00000000 03
2 2 4 00000000 80
2 6 4 00000000 fd
# burst larger than the queue with responses held
3 0 0 00000001 00
2 3 2 00000000 5b
2 1 0 00000000 7f
2 2 4 00000000 80
2 7 5 00000000 9c
2 0 2 00000000 01
2 1 2 00000000 ff
2 f 7 00000000 00
2 6 4 00000000 fd
3 0 0 00000000 00

//--- build.f
logic/weight_pkg.sv
logic/cmd_queue.sv
logic/weight_exec.sv
logic/weight_manager.sv
verification/weight_manager_props.sv
verification/weight_manager_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := weight_manager_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if its output holds the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
